// File: barrett.f
rtl/multiplier_pkg.sv
rtl/mult_if.sv
rtl/barrett_ctrl_if.sv
rtl/multiplier_top.sv
rtl/barrett_ctrl.sv
rtl/barrett_dp.sv
rtl/barrett_ds.sv
verification/barrett_sva.sv
verification/barrett_tb.sv

// File: rtl/barrett_ctrl.sv
`timescale 1ns/1ns

module barrett_ctrl (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         start_i,
  output logic         valid_o,
  barrett_ctrl_if.ctrl cif,
  mult_if.ctrl         mxm,
  mult_if.ctrl         mqm
);

  multiplier_pkg::barrett_state_t state_q, state_d;

  // ==============================
  // State register
  // ==============================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= multiplier_pkg::LOAD;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      multiplier_pkg::LOAD: begin
        if (start_i) begin
          state_d = multiplier_pkg::PRECOMP;
        end
      end
      multiplier_pkg::PRECOMP: begin
        if (mxm.finish) begin
          state_d = multiplier_pkg::APPROX_START;
        end
      end
      multiplier_pkg::APPROX_START: begin
        state_d = multiplier_pkg::APPROX;  // Estimate is registered by now.
      end
      multiplier_pkg::APPROX: begin
        if (mqm.finish) begin
          state_d = multiplier_pkg::REDUCE;
        end
      end
      multiplier_pkg::REDUCE: begin
        if (!cif.ge_q) begin
          state_d = multiplier_pkg::FINISH;  // Remainder below q.
        end
      end
      multiplier_pkg::FINISH: begin
        state_d = multiplier_pkg::LOAD;
      end
      default: begin
        state_d = multiplier_pkg::LOAD;
      end
    endcase
  end

  // ==============================
  // Strobe decode
  // ==============================

  // The first multiplier is idle only in the first PRECOMP cycle.
  assign mxm.start = (state_q == multiplier_pkg::PRECOMP) && !mxm.busy;
  assign mqm.start = (state_q == multiplier_pkg::APPROX_START) && !mqm.busy;

  always_comb begin
    cif.load        = (state_q == multiplier_pkg::LOAD) && start_i;
    cif.take_xmu    = (state_q == multiplier_pkg::PRECOMP) && mxm.finish;
    cif.take_qm     = (state_q == multiplier_pkg::APPROX) && mqm.finish;
    cif.subtract    = (state_q == multiplier_pkg::REDUCE) && cif.ge_q;
    cif.take_result = (state_q == multiplier_pkg::REDUCE) && !cif.ge_q;
  end

  assign valid_o = (state_q == multiplier_pkg::FINISH);  // One cycle pulse.

endmodule : barrett_ctrl

// File: rtl/barrett_ctrl_if.sv
`timescale 1ns/1ns

interface barrett_ctrl_if;

  logic load;         // Capture operands.
  logic take_xmu;     // Register quotient estimate.
  logic take_qm;      // Register x minus estimate times q.
  logic subtract;     // Remainder minus q.
  logic take_result;  // Copy remainder to output.
  logic ge_q;         // Remainder at least q.

  modport ctrl (
    output load,
    output take_xmu,
    output take_qm,
    output subtract,
    output take_result,
    input  ge_q
  );

  modport dp (
    input  load,
    input  take_xmu,
    input  take_qm,
    input  subtract,
    input  take_result,
    output ge_q
  );

endinterface : barrett_ctrl_if

// File: rtl/barrett_dp.sv
`timescale 1ns/1ns

module barrett_dp #(
  parameter int DATA_LENGTH = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [DATA_LENGTH-1:0] x_i,
  input  logic [DATA_LENGTH-1:0] q_i,
  input  logic [DATA_LENGTH-1:0] q_bl_i,
  input  logic [DATA_LENGTH-1:0] mu_i,
  output logic [DATA_LENGTH-1:0] result_o,
  barrett_ctrl_if.dp             cif,
  mult_if.operand                mxm,
  mult_if.operand                mqm
);

  logic [DATA_LENGTH-1:0]   x_q;         // Captured input.
  logic [DATA_LENGTH-1:0]   q_q;         // Captured modulus.
  logic [DATA_LENGTH-1:0]   q_bl_q;      // Captured modulus bit length.
  logic [DATA_LENGTH-1:0]   mu_q;        // Captured mu.
  logic [DATA_LENGTH-1:0]   rem_q;       // Estimate, then remainder.
  logic [DATA_LENGTH-1:0]   result_q;
  logic [DATA_LENGTH:0]     shamt;       // Twice the bit length.
  logic [2*DATA_LENGTH-1:0] xmu_shifted;

  // ==============================
  // Operand capture
  // ==============================

  always_ff @(posedge clk_i) begin
    if (cif.load) begin
      x_q    <= x_i;
      q_q    <= q_i;
      q_bl_q <= q_bl_i;
      mu_q   <= mu_i;
    end
  end

  // ==============================
  // Quotient estimate and remainder
  // ==============================

  assign shamt       = {q_bl_q, 1'b0};
  assign xmu_shifted = mxm.r >> shamt;  // Floor of x*mu / 4^k.

  always_ff @(posedge clk_i) begin
    if (cif.take_xmu) begin
      rem_q <= xmu_shifted[DATA_LENGTH-1:0];  // Estimate fits in the word.
    end else if (cif.take_qm) begin
      rem_q <= x_q - mqm.r[DATA_LENGTH-1:0];  // Product never exceeds x.
    end else if (cif.subtract) begin
      rem_q <= rem_q - q_q;
    end
  end

  assign cif.ge_q = (rem_q >= q_q);

  // First multiplier gets x and mu, second the estimate and q.
  assign mxm.a = x_q;
  assign mxm.b = mu_q;
  assign mqm.a = rem_q;
  assign mqm.b = q_q;

  // ==============================
  // Result register
  // ==============================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      result_q <= '0;
    end else if (cif.take_result) begin
      result_q <= rem_q;  // Updated on entry to FINISH.
    end
  end

  assign result_o = result_q;

endmodule : barrett_dp

// File: rtl/barrett_ds.sv
`timescale 1ns/1ns

module barrett_ds #(
  parameter int DATA_LENGTH = multiplier_pkg::DATA_LENGTH_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic [DATA_LENGTH-1:0] x_i,       // Value to reduce.
  input  logic [DATA_LENGTH-1:0] q_i,       // Modulus.
  input  logic [DATA_LENGTH-1:0] q_bl_i,    // Modulus bit length.
  input  logic [DATA_LENGTH-1:0] mu_i,      // Precomputed mu.
  output logic [DATA_LENGTH-1:0] result_o,  // x mod q.
  output logic                   valid_o    // Result valid pulse.
);

  mult_if #(.DATA_LENGTH(DATA_LENGTH)) mul_xmu_if ();
  mult_if #(.DATA_LENGTH(DATA_LENGTH)) mul_qm_if ();
  barrett_ctrl_if                      ctrl_if ();

  barrett_ctrl u_ctrl (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start_i),
    .valid_o (valid_o),
    .cif     (ctrl_if.ctrl),
    .mxm     (mul_xmu_if.ctrl),
    .mqm     (mul_qm_if.ctrl)
  );

  barrett_dp #(
    .DATA_LENGTH (DATA_LENGTH)
  ) u_dp (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .x_i      (x_i),
    .q_i      (q_i),
    .q_bl_i   (q_bl_i),
    .mu_i     (mu_i),
    .result_o (result_o),
    .cif      (ctrl_if.dp),
    .mxm      (mul_xmu_if.operand),
    .mqm      (mul_qm_if.operand)
  );

  // x times mu.
  multiplier_top #(
    .DATA_LENGTH (DATA_LENGTH)
  ) multiplier_precomp (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mul    (mul_xmu_if.unit)
  );

  // Estimate times q.
  multiplier_top #(
    .DATA_LENGTH (DATA_LENGTH)
  ) multiplier_approx (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mul    (mul_qm_if.unit)
  );

endmodule : barrett_ds

// File: rtl/mult_if.sv
`timescale 1ns/1ns

interface mult_if #(
  parameter int DATA_LENGTH = 16
);

  logic                       start;   // One cycle start strobe.
  logic                       busy;    // Multiplication in progress.
  logic                       finish;  // One cycle done pulse.
  logic [DATA_LENGTH-1:0]     a;       // Multiplicand.
  logic [DATA_LENGTH-1:0]     b;       // Multiplier.
  logic [2*DATA_LENGTH-1:0]   r;       // Product.

  // Sequencing side.
  modport ctrl (
    output start,
    input  busy,
    input  finish
  );

  // Operand and product side.
  modport operand (
    output a,
    output b,
    input  r
  );

  // The multiplier itself.
  modport unit (
    input  start,
    input  a,
    input  b,
    output busy,
    output finish,
    output r
  );

endinterface : mult_if

// File: rtl/multiplier_pkg.sv
package multiplier_pkg;

  // ==============================
  // Word width
  // ==============================

  localparam int DATA_LENGTH_DEFAULT = 16;  // Operand width in bits.

  // ==============================
  // Reduction controller states
  // ==============================

  typedef enum logic [2:0] {
    LOAD,          // Wait for start, capture operands.
    PRECOMP,       // x times mu on the first multiplier.
    APPROX_START,  // One cycle gap, second multiplier start.
    APPROX,        // Estimate times q on the second multiplier.
    REDUCE,        // Conditional subtraction of q.
    FINISH         // Result valid.
  } barrett_state_t;

  // ==============================
  // Serial multiplier states
  // ==============================

  typedef enum logic [1:0] {
    IDLE,  // Waiting for start.
    RUN,   // One multiplier bit per cycle.
    DONE   // Product ready, finish pulse.
  } mult_state_t;

endpackage : multiplier_pkg

// File: rtl/multiplier_top.sv
`timescale 1ns/1ns

module multiplier_top #(
  parameter int DATA_LENGTH = 16
) (
  input  logic clk_i,
  input  logic rst_ni,
  mult_if.unit mul
);

  localparam int CW = $clog2(DATA_LENGTH);

  multiplier_pkg::mult_state_t state_q, state_d;

  logic [CW-1:0]            cnt_q;    // Bit position being processed.
  logic [2*DATA_LENGTH-1:0] a_sh_q;   // Multiplicand, shifted left each cycle.
  logic [DATA_LENGTH-1:0]   b_sh_q;   // Multiplier, shifted right each cycle.
  logic [2*DATA_LENGTH-1:0] acc_q;    // Partial product.
  logic                     last_bit;

  assign last_bit = (cnt_q == CW'(DATA_LENGTH - 1));

  // ==============================
  // State register
  // ==============================

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= multiplier_pkg::IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == multiplier_pkg::RUN) begin
        cnt_q <= cnt_q + 1'b1;  // Wraps back to zero after the last bit.
      end else begin
        cnt_q <= '0;
      end
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      multiplier_pkg::IDLE: begin
        if (mul.start) begin
          state_d = multiplier_pkg::RUN;
        end
      end
      multiplier_pkg::RUN: begin
        if (last_bit) begin
          state_d = multiplier_pkg::DONE;
        end
      end
      multiplier_pkg::DONE: begin
        state_d = multiplier_pkg::IDLE;  // Finish lasts one cycle.
      end
      default: begin
        state_d = multiplier_pkg::IDLE;
      end
    endcase
  end

  // ==============================
  // Shift-add datapath
  // ==============================

  always_ff @(posedge clk_i) begin
    if (state_q == multiplier_pkg::IDLE && mul.start) begin
      a_sh_q <= {{DATA_LENGTH{1'b0}}, mul.a};  // Latch operands.
      b_sh_q <= mul.b;
      acc_q  <= '0;
    end else if (state_q == multiplier_pkg::RUN) begin
      if (b_sh_q[0]) begin
        acc_q <= acc_q + a_sh_q;  // Add shifted multiplicand.
      end
      a_sh_q <= a_sh_q << 1;
      b_sh_q <= b_sh_q >> 1;
    end
  end

  // Busy covers the run and the finish cycle.
  assign mul.busy   = (state_q == multiplier_pkg::RUN) || (state_q == multiplier_pkg::DONE);
  assign mul.finish = (state_q == multiplier_pkg::DONE);
  assign mul.r      = acc_q;  // Holds until the next start.

endmodule : multiplier_top

// File: run_sim.sh
#!/bin/sh
# Build and run the barrett testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module barrett_tb \
  -f barrett.f \
  -o barrett_sim

output=$(./obj_dir/barrett_sim)
echo "$output"

if echo "$output" | grep -qx "=== PASS ==="; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: verification/barrett_sva.sv
`timescale 1ns/1ns

module barrett_sva #(
  parameter int DATA_LENGTH = 16
) (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           start_i,
  input logic [DATA_LENGTH-1:0]         q_i,
  input logic                           valid_i,
  input logic [DATA_LENGTH-1:0]         result_i,
  input multiplier_pkg::barrett_state_t ctrl_state_i,
  input multiplier_pkg::mult_state_t    xmu_state_i,
  input logic                           xmu_busy_i,
  input logic                           xmu_finish_i,
  input logic                           qm_busy_i,
  input logic                           qm_finish_i
);

  logic [DATA_LENGTH-1:0] q_cap_q;  // Modulus of the request in flight.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_cap_q <= '0;
    end else if (ctrl_state_i == multiplier_pkg::LOAD && start_i) begin
      q_cap_q <= q_i;
    end
  end

  // ==============================
  // Result handshake
  // ==============================

  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !valid_i) else $error("valid_o high on two consecutive cycles");

  a_valid_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !valid_i) else $error("valid_o high during reset");

  a_result_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (result_i < q_cap_q)) else $error("result_o not below q");

  // ==============================
  // Multiplier protocol
  // ==============================

  a_xmu_finish: assert property (@(posedge clk_i) disable iff (!rst_ni)
    xmu_finish_i |-> $past(xmu_busy_i))
    else $error("first multiplier finished without running");

  a_qm_finish: assert property (@(posedge clk_i) disable iff (!rst_ni)
    qm_finish_i |-> $past(qm_busy_i)) else $error("second multiplier finished without running");

  // Between requests the first multiplier waits for a new start.
  a_xmu_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (ctrl_state_i == multiplier_pkg::LOAD) |-> (xmu_state_i == multiplier_pkg::IDLE))
    else $error("first multiplier not idle between requests");

endmodule : barrett_sva

bind barrett_ds barrett_sva #(.DATA_LENGTH(DATA_LENGTH)) u_sva (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .start_i      (start_i),
  .q_i          (q_i),
  .valid_i      (valid_o),
  .result_i     (result_o),
  .ctrl_state_i (u_ctrl.state_q),
  .xmu_state_i  (multiplier_precomp.state_q),
  .xmu_busy_i   (mul_xmu_if.busy),
  .xmu_finish_i (mul_xmu_if.finish),
  .qm_busy_i    (mul_qm_if.busy),
  .qm_finish_i  (mul_qm_if.finish)
);

// File: verification/barrett_tb.sv
`timescale 1ns/1ns

module barrett_tb;

  localparam int DL           = multiplier_pkg::DATA_LENGTH_DEFAULT;
  localparam int CLK_HALF     = 4;
  localparam int MAX_LATENCY  = 2 * DL + 8;   // Longest request, two subtractions.
  localparam int REQ_CYCLES   = 2 * DL + 10;  // Worst case latency plus margin.
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_REQUESTS = 20 + NUM_RANDOM + 1 + 8;
  localparam int WATCHDOG_NS  = ((NUM_REQUESTS + 10) * REQ_CYCLES + 3 * NUM_RANDOM) * 2 * CLK_HALF;

  logic          clk;
  logic          rst_n;
  logic          start;
  logic [DL-1:0] x;
  logic [DL-1:0] q;
  logic [DL-1:0] q_bl;
  logic [DL-1:0] mu;
  logic [DL-1:0] result;
  logic          valid;

  int unsigned err_count;
  int unsigned check_count;
  int unsigned test_count;
  int unsigned last_result;      // Last completed result, must hold.
  int unsigned valid_count = 0;

  barrett_ds #(.DATA_LENGTH(DL)) uut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .x_i      (x),
    .q_i      (q),
    .q_bl_i   (q_bl),
    .mu_i     (mu),
    .result_o (result),
    .valid_o  (valid)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    if (valid) valid_count <= valid_count + 1;  // Pulses seen so far.
  end

  // ==============================
  // Reference model
  // ==============================

  function automatic int unsigned bit_length(input int unsigned v);
    int unsigned n;
    n = 0;
    while (v != 0) begin
      n++;
      v = v >> 1;
    end
    return n;
  endfunction

  function automatic int unsigned model_mu(input int unsigned qv);
    return (32'd1 << (2 * bit_length(qv))) / qv;  // floor(4^k / q).
  endfunction

  function automatic int unsigned model_mod(input int unsigned xv, input int unsigned qv);
    return xv % qv;
  endfunction

  // ==============================
  // Helpers
  // ==============================

  task automatic check_value(input string sig, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t ns", sig, actual, expected, $time);
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) @(posedge clk);
  endtask

  // Called right after a rising edge.
  task automatic issue_start(input int unsigned xv, input int unsigned qv);
    start <= 1'b1;
    x     <= xv[DL-1:0];
    q     <= qv[DL-1:0];
    q_bl  <= DL'(bit_length(qv));
    mu    <= DL'(model_mu(qv));
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_result(output int unsigned res, output bit got);
    int unsigned cycles;
    got    = 1'b0;
    res    = 0;
    cycles = 0;
    while (!got && cycles < MAX_LATENCY) begin
      @(posedge clk);
      cycles++;
      if (valid) begin
        got = 1'b1;
        res = 32'(result);
      end else begin
        check_value("result_o hold", 32'(result), last_result);
      end
    end
    if (!got) begin
      err_count++;
      $display("Request timed out: no valid_o pulse within %0d cycles", MAX_LATENCY);
    end
  endtask

  task automatic run_request(input int unsigned xv, input int unsigned qv);
    int unsigned res;
    bit          got;
    issue_start(xv, qv);
    wait_result(res, got);
    if (got) begin
      check_value("result_o", res, model_mod(xv, qv));
      last_result = res;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned err_start);
    test_count++;
    $display("Test %-14s finished with %0d errors", name, err_count - err_start);
  endtask

  // ==============================
  // Directed tests
  // ==============================

  task automatic test_reset();
    int unsigned e0;
    e0 = err_count;
    repeat (3) begin
      @(posedge clk);
      check_value("valid_o", 32'(valid), 0);
      check_value("result_o", 32'(result), 0);
    end
    rst_n <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_value("valid_o", 32'(valid), 0);
      check_value("result_o", 32'(result), 0);
    end
    finish_test("reset", e0);
  endtask

  task automatic test_fixed();
    int unsigned qs[4];
    int unsigned xs[5];
    int unsigned e0;
    int unsigned v0;
    int unsigned k;
    e0 = err_count;
    v0 = valid_count;
    qs = '{2, 3, 255, 251};
    foreach (qs[i]) begin
      k  = bit_length(qs[i]);
      xs = '{0, qs[i] - 1, qs[i], qs[i] * qs[i] - 1, (32'd1 << (2 * k)) - 1};
      foreach (xs[j]) begin
        run_request(xs[j], qs[i]);
        idle_cycles(1);
      end
    end
    idle_cycles(2);
    check_value("valid_o pulse count", valid_count - v0, 20);
    finish_test("fixed", e0);
  endtask

  task automatic test_random();
    int unsigned e0;
    int unsigned v0;
    int unsigned k;
    int unsigned qv;
    e0 = err_count;
    v0 = valid_count;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      k  = 2 + ($urandom % (DL / 2 - 1));  // Bit length 2 to DL/2.
      qv = (32'd1 << (k - 1)) + ($urandom % (32'd1 << (k - 1)));
      run_request($urandom % (32'd1 << (2 * k)), qv);
      idle_cycles($urandom % 3);
    end
    idle_cycles(2);
    check_value("valid_o pulse count", valid_count - v0, NUM_RANDOM);
    finish_test("random", e0);
  endtask

  task automatic test_ignored_start();
    int unsigned e0;
    int unsigned v0;
    int unsigned res;
    bit          got;
    e0 = err_count;
    v0 = valid_count;
    issue_start(12345, 97);
    idle_cycles(2);
    issue_start(500, 13);  // Lands in PRECOMP.
    idle_cycles(15);
    issue_start(40, 7);    // Lands near APPROX_START.
    wait_result(res, got);
    if (got) begin
      check_value("result_o", res, model_mod(12345, 97));
      last_result = res;
    end
    idle_cycles(REQ_CYCLES);
    check_value("valid_o pulse count", valid_count - v0, 1);
    finish_test("ignored_start", e0);
  endtask

  task automatic test_back_to_back();
    int unsigned xs[8];
    int unsigned qs[8];
    int unsigned e0;
    int unsigned v0;
    e0 = err_count;
    v0 = valid_count;
    xs = '{65535, 0, 1234, 16383, 9, 65000, 777, 15};
    qs = '{255, 2, 37, 127, 3, 251, 200, 2};
    foreach (xs[i]) begin
      run_request(xs[i], qs[i]);  // Next start in the cycle after valid_o.
    end
    idle_cycles(2);
    check_value("valid_o pulse count", valid_count - v0, 8);
    finish_test("back_to_back", e0);
  endtask

  // ==============================
  // Main sequence and watchdog
  // ==============================

  initial begin
    void'($urandom(32'h7fbb_6e49));
    rst_n       = 1'b0;
    start       = 1'b0;
    x           = '0;
    q           = '0;
    q_bl        = '0;
    mu          = '0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    last_result = 0;
    test_reset();
    test_fixed();
    test_random();
    test_ignored_start();
    test_back_to_back();
    $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not complete within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule : barrett_tb
